// ==== Makefile ====
# Verilator build and run of the LCD controller testbench

VERILATOR ?= verilator
TOP       ?= lcd_tb
FLAGS     ?= --binary --timing --timescale 1ns/1ns
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# Build, run, and succeed only when the pass line shows up
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f build.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
source/lcd_pkg.sv
source/wb_pkg.sv
source/lcd_nibble_if.sv
source/lcd_byte_fifo.sv
source/lcd_wb_slave.sv
source/lcd_ctrl.sv
source/lcd_strobe_gen.sv
source/lcd_top.sv
verification/lcd_tb.sv

// ==== source/lcd_byte_fifo.sv ====
// ----------------------------------------------------------
// Synchronous FIFO of queued LCD bytes
// Circular buffer with occupancy count, full and empty flags
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module lcd_byte_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 push,
  input  wire lcd_pkg::lcd_byte_t push_data,
  output logic                full,
  input  wire                 pop,
  output lcd_pkg::lcd_byte_t  pop_data,
  output logic                empty
);

  import lcd_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  lcd_byte_t        mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign full  = (count == CNT_W'(FIFO_DEPTH));
  assign empty = (count == '0);

  // Push dropped when full, pop dropped when empty
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  // Head entry, valid while not empty
  assign pop_data = mem[rd_ptr];

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap at depth, works for any depth
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves count alone
      if (do_push & ~do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop & ~do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/lcd_ctrl.sv ====
// ----------------------------------------------------------
// LCD control FSM
// Plays the power-up table, then fetches queued bytes and
// issues each as high nibble then low nibble
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module lcd_ctrl (
  input  wire                     clk,
  input  wire                     rst,
  // FIFO read side
  input  wire lcd_pkg::lcd_byte_t pop_data,
  input  wire                     empty,
  output logic                    pop,
  // Nibble stream to the strobe generator
  lcd_nibble_if.src               nib_out,
  // Status back to the bus slave
  output logic                    busy,
  output logic                    init_done
);

  import lcd_pkg::*;

  localparam int IDX_W = (INIT_LEN > 1) ? $clog2(INIT_LEN) : 1;

  typedef enum logic [1:0] {
    S_INIT,
    S_IDLE,
    S_HI,
    S_LO
  } state_t;

  state_t           state;
  logic [IDX_W-1:0] init_idx;
  lcd_byte_t        cur_byte;
  logic             xfer;

  // Handshake completes this cycle
  assign xfer = nib_out.valid & nib_out.ready;

  // Take the head byte as soon as the FSM is free
  assign pop = (state == S_IDLE) & ~empty;

  // Anything queued, pending or still on the pins
  assign busy = ~empty | nib_out.valid | ~nib_out.ready;

  // ----------------------------------------------------------
  // Sequencer
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= S_INIT;
      init_idx      <= '0;
      init_done     <= 1'b0;
      nib_out.valid <= 1'b0;
    end else begin
      case (state)
        // Table entries, one at a time
        S_INIT: begin
          if (!nib_out.valid) begin
            nib_out.valid <= 1'b1;
          end else if (xfer) begin
            nib_out.valid <= 1'b0;
            if (init_idx == IDX_W'(INIT_LEN - 1)) begin
              // Last power-up nibble accepted
              init_done <= 1'b1;
              state     <= S_IDLE;
            end else begin
              init_idx <= init_idx + 1'b1;
            end
          end
        end
        // Wait for a queued byte
        S_IDLE: begin
          if (!empty) begin
            nib_out.valid <= 1'b1;
            state         <= S_HI;
          end
        end
        // High nibble out, low nibble follows
        S_HI: begin
          if (xfer) begin
            state <= S_LO;
          end
        end
        S_LO: begin
          if (xfer) begin
            nib_out.valid <= 1'b0;
            state         <= S_IDLE;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // Nibble payload
  // ----------------------------------------------------------
  // Changes only when valid is low or a transfer just happened
  always_ff @(posedge clk) begin
    if ((state == S_INIT) && !nib_out.valid) begin
      nib_out.nib <= INIT_TABLE[init_idx];
    end else if (pop) begin
      cur_byte    <= pop_data;
      nib_out.nib <= '{rs: pop_data.rs, data: pop_data.data[7:4]};
    end else if ((state == S_HI) && xfer) begin
      nib_out.nib <= '{rs: cur_byte.rs, data: cur_byte.data[3:0]};
    end
  end

endmodule

`default_nettype wire

// ==== source/lcd_nibble_if.sv ====
// ----------------------------------------------------------
// Nibble handshake from the control FSM to the strobe
// generator, valid/ready with one nibble and its RS flag
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

interface lcd_nibble_if;

  import lcd_pkg::*;

  // Source holds valid and nib until ready is seen
  logic        valid;
  logic        ready;
  lcd_nibble_t nib;

  // Control side
  modport src (
    output valid,
    output nib,
    input  ready
  );

  // Pin driver side
  modport snk (
    input  valid,
    input  nib,
    output ready
  );

endinterface

`default_nettype wire

// ==== source/lcd_pkg.sv ====
// ----------------------------------------------------------
// Display-side definitions for the HD44780 4-bit interface
// Queued byte and nibble structs, command codes and the
// power-up nibble table
// ----------------------------------------------------------
`default_nettype none

package lcd_pkg;

  // Queued byte, rs 1 selects character data, rs 0 a command
  typedef struct packed {
    logic       rs;
    logic [7:0] data;
  } lcd_byte_t;

  // One transfer on D7..D4 with its register select
  typedef struct packed {
    logic       rs;
    logic [3:0] data;
  } lcd_nibble_t;

  // ----------------------------------------------------------
  // Power-up sequence
  // ----------------------------------------------------------
  localparam int INIT_LEN = 4;

  // 8-bit wake nibble, switch to 4-bit, then display on with cursor
  localparam lcd_nibble_t [0:INIT_LEN-1] INIT_TABLE = {
    5'h03, 5'h02, 5'h00, 5'h0E
  };

  // Common command bytes
  localparam logic [7:0] CMD_CLEAR = 8'h01;
  localparam logic [7:0] CMD_HOME  = 8'h02;
  // DDRAM address 0x40, start of line 2
  localparam logic [7:0] CMD_LINE2 = 8'hC0;

endpackage

`default_nettype wire

// ==== source/lcd_strobe_gen.sv ====
// ----------------------------------------------------------
// LCD pin driver
// Latches one nibble onto RS and D7..D4, then shapes the E
// pulse with setup, pulse and gap phases
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module lcd_strobe_gen #(
  parameter int SETUP_CYCLES = 2,
  parameter int PULSE_CYCLES = 4,
  parameter int GAP_CYCLES   = 8
) (
  input  wire        clk,
  input  wire        rst,
  lcd_nibble_if.snk  nib_in,
  output logic       lcd_rs,
  output logic       lcd_e,
  output logic [3:0] lcd_d
);

  localparam int MAX_A = (SETUP_CYCLES > PULSE_CYCLES) ? SETUP_CYCLES : PULSE_CYCLES;
  localparam int MAX_CYC = (MAX_A > GAP_CYCLES) ? MAX_A : GAP_CYCLES;
  localparam int CNT_W = $clog2(MAX_CYC + 1);

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_SETUP,
    PH_PULSE,
    PH_GAP
  } phase_t;

  phase_t           phase;
  logic [CNT_W-1:0] cnt;

  // Next nibble taken only between strobes
  assign nib_in.ready = (phase == PH_IDLE);

  // Down counter per phase, pins only move in idle
  always_ff @(posedge clk) begin
    if (rst) begin
      phase  <= PH_IDLE;
      cnt    <= '0;
      lcd_e  <= 1'b0;
      lcd_rs <= 1'b0;
      lcd_d  <= '0;
    end else begin
      case (phase)
        PH_IDLE: begin
          if (nib_in.valid) begin
            lcd_rs <= nib_in.nib.rs;
            lcd_d  <= nib_in.nib.data;
            cnt    <= CNT_W'(SETUP_CYCLES - 1);
            phase  <= PH_SETUP;
          end
        end
        // Address setup before E
        PH_SETUP: begin
          if (cnt == '0) begin
            lcd_e <= 1'b1;
            cnt   <= CNT_W'(PULSE_CYCLES - 1);
            phase <= PH_PULSE;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        // E high, falling edge latches the nibble
        PH_PULSE: begin
          if (cnt == '0) begin
            lcd_e <= 1'b0;
            cnt   <= CNT_W'(GAP_CYCLES - 1);
            phase <= PH_GAP;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        // Hold time plus execution gap
        default: begin
          if (cnt == '0) begin
            phase <= PH_IDLE;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/lcd_top.sv ====
// ----------------------------------------------------------
// LCD controller top level
// Wishbone slave, byte FIFO, control FSM and pin driver
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module lcd_top #(
  parameter int FIFO_DEPTH   = 8,
  parameter int SETUP_CYCLES = 2,
  parameter int PULSE_CYCLES = 4,
  parameter int GAP_CYCLES   = 8
) (
  input  wire                         clk,
  input  wire                         rst,
  // Wishbone classic
  input  wire [wb_pkg::WB_ADR_W-1:0]  wb_adr,
  input  wire [wb_pkg::WB_DAT_W-1:0]  wb_dat_w,
  output logic [wb_pkg::WB_DAT_W-1:0] wb_dat_r,
  input  wire                         wb_we,
  input  wire                         wb_stb,
  input  wire                         wb_cyc,
  output logic                        wb_ack,
  // HD44780 pins, 4-bit mode
  output logic                        lcd_rs,
  output logic                        lcd_e,
  output logic [3:0]                  lcd_d
);

  import lcd_pkg::*;

  logic      push;
  lcd_byte_t push_data;
  logic      full;
  logic      pop;
  lcd_byte_t pop_data;
  logic      empty;
  logic      busy;
  logic      init_done;

  lcd_nibble_if nib_if ();

  lcd_wb_slave u_slave (
    .clk(clk), .rst(rst),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
    .wb_we(wb_we), .wb_stb(wb_stb), .wb_cyc(wb_cyc), .wb_ack(wb_ack),
    .push(push), .push_data(push_data), .full(full),
    .busy(busy), .init_done(init_done)
  );

  lcd_byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk(clk), .rst(rst),
    .push(push), .push_data(push_data), .full(full),
    .pop(pop), .pop_data(pop_data), .empty(empty)
  );

  lcd_ctrl u_ctrl (
    .clk(clk), .rst(rst),
    .pop_data(pop_data), .empty(empty), .pop(pop),
    .nib_out(nib_if.src), .busy(busy), .init_done(init_done)
  );

  lcd_strobe_gen #(
    .SETUP_CYCLES(SETUP_CYCLES),
    .PULSE_CYCLES(PULSE_CYCLES),
    .GAP_CYCLES(GAP_CYCLES)
  ) u_strobe (
    .clk(clk), .rst(rst), .nib_in(nib_if.snk),
    .lcd_rs(lcd_rs), .lcd_e(lcd_e), .lcd_d(lcd_d)
  );

endmodule

`default_nettype wire

// ==== source/lcd_wb_slave.sv ====
// ----------------------------------------------------------
// Wishbone classic slave for the LCD controller
// Data and command writes become FIFO pushes, status reads
// return full, busy and init_done
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module lcd_wb_slave (
  input  wire                          clk,
  input  wire                          rst,
  // Wishbone classic
  input  wire [wb_pkg::WB_ADR_W-1:0]   wb_adr,
  input  wire [wb_pkg::WB_DAT_W-1:0]   wb_dat_w,
  output logic [wb_pkg::WB_DAT_W-1:0]  wb_dat_r,
  input  wire                          wb_we,
  input  wire                          wb_stb,
  input  wire                          wb_cyc,
  output logic                         wb_ack,
  // FIFO write side
  output logic                         push,
  output lcd_pkg::lcd_byte_t           push_data,
  input  wire                          full,
  // Controller status
  input  wire                          busy,
  input  wire                          init_done
);

  import wb_pkg::*;

  logic                req;
  logic                fifo_wr;
  logic                can_done;
  logic [WB_DAT_W-1:0] status;

  // ----------------------------------------------------------
  // Request decode
  // ----------------------------------------------------------
  // New request only when not already in the ack cycle
  assign req = wb_cyc & wb_stb & ~wb_ack;

  // Writes that land in the FIFO
  assign fifo_wr = wb_we & ((wb_adr == REG_DATA) | (wb_adr == REG_CMD));

  // Queue writes stall while full, all else completes at once
  assign can_done = ~fifo_wr | ~full;

  // Status byte, unused bits read as zero
  always_comb begin
    status               = '0;
    status[ST_FULL]      = full;
    status[ST_BUSY]      = busy;
    status[ST_INIT_DONE] = init_done;
  end

  // ----------------------------------------------------------
  // Registered ack and push
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
      push   <= 1'b0;
    end else begin
      // Single-cycle ack, push rides along with it
      wb_ack <= req & can_done;
      push   <= req & can_done & fifo_wr;
    end
  end

  // Payload, captured with the request
  always_ff @(posedge clk) begin
    if (req & can_done) begin
      // Command register clears RS
      push_data.rs   <= (wb_adr == REG_DATA);
      push_data.data <= wb_dat_w;
      // Only the status register reads back
      if (wb_adr == REG_STATUS) begin
        wb_dat_r <= status;
      end else begin
        wb_dat_r <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/wb_pkg.sv ====
// ----------------------------------------------------------
// Bus-side definitions for the Wishbone register port
// Widths, register map and status bit positions
// ----------------------------------------------------------
`default_nettype none

package wb_pkg;

  // Bus widths
  localparam int WB_ADR_W = 2;
  localparam int WB_DAT_W = 8;

  // Register map
  localparam logic [WB_ADR_W-1:0] REG_DATA   = 2'd0;
  localparam logic [WB_ADR_W-1:0] REG_CMD    = 2'd1;
  localparam logic [WB_ADR_W-1:0] REG_STATUS = 2'd2;

  // Status byte layout
  localparam int ST_FULL      = 0;
  localparam int ST_BUSY      = 1;
  localparam int ST_INIT_DONE = 2;

endpackage

`default_nettype wire

// ==== verification/lcd_cases.txt ====
# name op arg0 arg1 exp0 exp1, hex; init/data/cmd expect two strobes, each rs*10 + nibble
# data/cmd arg0 byte; burst arg0 count, arg1 start byte; burst/status exp mask, value
init_wake    init    00 00 03 02
init_display init    00 00 00 0e
init_status  status  00 00 04 04
char_h       data    48 00 14 18
char_i       data    69 00 16 19
char_tilde   data    7e 00 17 1e
cmd_line2    cmd     c0 00 0c 00
cmd_clear    cmd     01 00 00 01
cmd_home     cmd     02 00 00 02
char_ones    data    ff 00 1f 1f
burst_fill   burst   0c 30 01 01
idle_status  status  00 00 07 04

// ==== verification/lcd_tb.sv ====
// ----------------------------------------------------------
// Self-checking testbench for the LCD controller
// Case-file driven Wishbone stimulus, LCD pin decoder,
// strobe and status checks, watchdog
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module lcd_tb;

  import wb_pkg::*;

  localparam int FIFO_DEPTH   = 8;
  localparam int BURST_LEN    = FIFO_DEPTH + 4;
  localparam int SETUP_CYCLES = 2;
  localparam int PULSE_CYCLES = 4;
  localparam int GAP_CYCLES   = 8;
  // Handshake cycle plus the three strobe phases
  localparam int NIB_CYCLES   = 1 + SETUP_CYCLES + PULSE_CYCLES + GAP_CYCLES;
  localparam int POLL_LIMIT   = 16;
  localparam int MAX_CASES    = 32;

  // Operation words as written in the case file
  localparam logic [47:0] OP_INIT   = "init";
  localparam logic [47:0] OP_DATA   = "data";
  localparam logic [47:0] OP_CMD    = "cmd";
  localparam logic [47:0] OP_BURST  = "burst";
  localparam logic [47:0] OP_STATUS = "status";

  logic                clk;
  logic                rst;
  logic [WB_ADR_W-1:0] wb_adr;
  logic [WB_DAT_W-1:0] wb_dat_w;
  logic [WB_DAT_W-1:0] wb_dat_r;
  logic                wb_we;
  logic                wb_stb;
  logic                wb_cyc;
  logic                wb_ack;
  logic                lcd_rs;
  logic                lcd_e;
  logic [3:0]          lcd_d;

  // Case table
  logic [127:0] case_name [MAX_CASES];
  logic [47:0]  case_op   [MAX_CASES];
  logic [7:0]   case_arg  [MAX_CASES][4];
  int           num_cases;

  // Decoded strobes, RS in bit 4
  logic [4:0] strobe_q [$];
  logic [4:0] pins_at_rise;
  logic       e_prev;

  int errors;
  int fails;
  int case_bad;
  int wd_cycles;

  lcd_top #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .SETUP_CYCLES(SETUP_CYCLES),
    .PULSE_CYCLES(PULSE_CYCLES),
    .GAP_CYCLES(GAP_CYCLES)
  ) UUT (
    .clk(clk), .rst(rst),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
    .wb_we(wb_we), .wb_stb(wb_stb), .wb_cyc(wb_cyc), .wb_ack(wb_ack),
    .lcd_rs(lcd_rs), .lcd_e(lcd_e), .lcd_d(lcd_d)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Pin monitor
  // ----------------------------------------------------------
  // Sampled mid-cycle, E falling edge pushes RS and D7..D4
  always @(negedge clk) begin
    if (rst) begin
      e_prev <= 1'b0;
    end else begin
      if (!e_prev && lcd_e) begin
        pins_at_rise <= {lcd_rs, lcd_d};
      end
      if (e_prev && lcd_e && ({lcd_rs, lcd_d} != pins_at_rise)) begin
        $display("LCD data pins changed while E was high at %0t ns", $time);
        errors++;
      end
      if (e_prev && !lcd_e) begin
        strobe_q.push_back({lcd_rs, lcd_d});
      end
      e_prev <= lcd_e;
    end
  end

  // Stalled output ends the run
  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    $display("timeout: LCD output stalled");
    $display("SIMULATION FAILED");
    $finish;
  end

  // ----------------------------------------------------------
  // Bus and check tasks
  // ----------------------------------------------------------
  // Classic cycle held until ack, read data taken in the ack cycle
  task automatic wishbone_cycle(input logic [WB_ADR_W-1:0] adr, input logic we,
                                input logic [WB_DAT_W-1:0] wdata,
                                output logic [WB_DAT_W-1:0] rdata);
    @(posedge clk);
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    wb_we    <= we;
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    @(negedge clk);
    while (!wb_ack) begin
      @(negedge clk);
    end
    rdata = wb_dat_r;
  endtask

  task automatic end_cycle();
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  // Next decoded strobe against one expected RS and nibble
  task automatic check_nibble(input int c, input int idx, input logic [4:0] exp);
    logic [4:0] got;
    while (strobe_q.size() == 0) begin
      @(negedge clk);
    end
    got = strobe_q.pop_front();
    if (got != exp) begin
      $display("mismatch %0s strobe %0d: expected rs %b d %h, actual rs %b d %h",
               case_name[c], idx, exp[4], exp[3:0], got[4], got[3:0]);
      case_bad++;
    end
  endtask

  // Status reads repeat until the masked bits settle or the limit runs out
  task automatic poll_status(input int c);
    logic [WB_DAT_W-1:0] st;
    int                  tries;
    tries = 0;
    do begin
      wishbone_cycle(REG_STATUS, 1'b0, 8'h00, st);
      end_cycle();
      tries++;
    end while (((st & case_arg[c][2]) != case_arg[c][3]) && (tries < POLL_LIMIT));
    if ((st & case_arg[c][2]) != case_arg[c][3]) begin
      $display("mismatch %0s status: expected %h, actual %h",
               case_name[c], case_arg[c][3], st & case_arg[c][2]);
      case_bad++;
    end
  endtask

  // Back-to-back data writes, one status read, then every byte off the pins
  task automatic run_burst(input int c);
    logic [WB_DAT_W-1:0] rd;
    logic [7:0]          b;
    if (case_arg[c][0] != 8'(BURST_LEN)) begin
      $display("%0s: burst count %0d is not the testbench burst length %0d",
               case_name[c], case_arg[c][0], BURST_LEN);
      case_bad++;
    end
    for (int k = 0; k < int'(case_arg[c][0]); k++) begin
      b = case_arg[c][1] + 8'(k);
      wishbone_cycle(REG_DATA, 1'b1, b, rd);
    end
    // Queue still backed up right after the last ack
    wishbone_cycle(REG_STATUS, 1'b0, 8'h00, rd);
    end_cycle();
    if ((rd & case_arg[c][2]) != case_arg[c][3]) begin
      $display("mismatch %0s status: expected %h, actual %h",
               case_name[c], case_arg[c][3], rd & case_arg[c][2]);
      case_bad++;
    end
    // High nibble first, RS 1 for data
    for (int k = 0; k < int'(case_arg[c][0]); k++) begin
      b = case_arg[c][1] + 8'(k);
      check_nibble(c, 2 * k, {1'b1, b[7:4]});
      check_nibble(c, 2 * k + 1, {1'b1, b[3:0]});
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    int                  fd;
    int                  n;
    int                  total_nib;
    string               line;
    logic [127:0]        nm;
    logic [47:0]         op;
    logic [7:0]          arg [4];
    logic [WB_ADR_W-1:0] adr;
    logic [WB_DAT_W-1:0] rd;
    rst       <= 1'b1;
    wb_adr    <= '0;
    wb_dat_w  <= '0;
    wb_we     <= 1'b0;
    wb_stb    <= 1'b0;
    wb_cyc    <= 1'b0;
    errors    = 0;
    fails     = 0;
    num_cases = 0;
    total_nib = 0;

    fd = $fopen("verification/lcd_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open the case file verification/lcd_cases.txt");
      errors++;
    end else begin
      while (!$feof(fd) && (num_cases < MAX_CASES)) begin
        line = "";
        void'($fgets(line, fd));
        if ((line.len() > 1) && (line.getc(0) != "#")) begin
          n = $sscanf(line, "%s %s %h %h %h %h", nm, op, arg[0], arg[1], arg[2], arg[3]);
          if (n == 6) begin
            case_name[num_cases] = nm;
            case_op[num_cases]   = op;
            for (int j = 0; j < 4; j++) begin
              case_arg[num_cases][j] = arg[j];
            end
            // Two strobes per byte, none for a status read
            if (op == OP_BURST) begin
              total_nib += 2 * int'(arg[0]);
            end else if (op != OP_STATUS) begin
              total_nib += 2;
            end
            num_cases++;
          end else begin
            $display("malformed line in the case file: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
    end

    // Strobe time with margin, plus bus and polling time
    wd_cycles = total_nib * (NIB_CYCLES * 4 + 4) + num_cases * POLL_LIMIT * 4 + 64;

    repeat (3) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < num_cases; i++) begin
      case_bad = 0;
      if (case_op[i] == OP_INIT) begin
        // Power-up strobes need no bus traffic
        check_nibble(i, 0, case_arg[i][2][4:0]);
        check_nibble(i, 1, case_arg[i][3][4:0]);
      end else if ((case_op[i] == OP_DATA) || (case_op[i] == OP_CMD)) begin
        adr = (case_op[i] == OP_DATA) ? REG_DATA : REG_CMD;
        wishbone_cycle(adr, 1'b1, case_arg[i][0], rd);
        end_cycle();
        check_nibble(i, 0, case_arg[i][2][4:0]);
        check_nibble(i, 1, case_arg[i][3][4:0]);
      end else if (case_op[i] == OP_BURST) begin
        run_burst(i);
      end else if (case_op[i] == OP_STATUS) begin
        poll_status(i);
      end else begin
        $display("unknown operation in case %0s", case_name[i]);
        case_bad++;
      end
      if (case_bad == 0) begin
        $display("test %0s: pass", case_name[i]);
      end else begin
        $display("test %0s: fail", case_name[i]);
        fails++;
      end
    end

    // Duplicated or stray strobes
    if (strobe_q.size() != 0) begin
      $display("%0d unexpected strobes left on the LCD pins", strobe_q.size());
      errors++;
    end
    $display("tests %0d, failed %0d, other errors %0d", num_cases, fails, errors);
    if ((fails == 0) && (errors == 0) && (num_cases > 0)) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
